// File: logic/bpu_entry_pkg.sv
package bpu_entry_pkg;

    // ==================================================
    // widths
    // ==================================================
    // prediction address
    localparam int pc_width   = 32;

    // base predictor counter, saturates at all ones
    localparam int ctr_width  = 2;

    // btb associativity and its pseudo-lru tree
    localparam int btb_ways   = 4;
    localparam int plru_width = btb_ways - 1;

    // ==================================================
    // one record per fetch block
    // ==================================================
    // plru node 0 is the root, node 1 covers ways 0/1, node 2 covers ways 2/3
    typedef struct packed {
        logic [pc_width-1:0]   pred_pc;
        logic [ctr_width-1:0]  ctr;
        logic [btb_ways-1:0]   way_valid;
        logic [btb_ways-1:0]   way_hit;
        logic [plru_width-1:0] plru;
    } bp_entry_t;

endpackage

// File: logic/ring_if.sv
`timescale 1ns/1ps

interface ring_if #(
    parameter int depth = 8
);

    localparam int idx_w = $clog2(depth);

    // write port
    logic             wr_en;
    logic [idx_w-1:0] wr_idx;

    // commit port, read-modify-write in place
    logic             cmt_en;
    logic [idx_w-1:0] cmt_idx;

    // read port, always open
    logic [idx_w-1:0] rd_idx;

    modport ctrl (output wr_en, wr_idx, cmt_en, cmt_idx, rd_idx);
    modport store (input wr_en, wr_idx, cmt_en, cmt_idx, rd_idx);

endinterface

// File: logic/plru_tree.sv
`timescale 1ns/1ps

module plru_tree
    import bpu_entry_pkg::*;
(
    input  logic [plru_width-1:0] node,
    input  logic [btb_ways-1:0]   touch_way,
    output logic [plru_width-1:0] touched,
    output logic [btb_ways-1:0]   victim
);

    logic touch_left;
    logic touch_right;

    assign touch_left  = touch_way[0] | touch_way[1];
    assign touch_right = touch_way[2] | touch_way[3];

    // ==================================================
    // touch, nodes point away from the used way
    // ==================================================
    always_comb begin
        touched = node;
        if (touch_left) begin
            touched[0] = 1'b1;
            touched[1] = touch_way[0];
        end else if (touch_right) begin
            touched[0] = 1'b0;
            touched[2] = touch_way[2];
        end
    end

    // ==================================================
    // victim walk from the root
    // ==================================================
    always_comb begin
        victim = '0;
        if (node[0]) begin
            // right half
            if (node[2]) begin
                victim[3] = 1'b1;
            end else begin
                victim[2] = 1'b1;
            end
        end else begin
            if (node[1]) begin
                victim[1] = 1'b1;
            end else begin
                victim[0] = 1'b1;
            end
        end
    end

endmodule

// File: logic/btb_way_alloc.sv
`timescale 1ns/1ps

module btb_way_alloc
    import bpu_entry_pkg::*;
(
    input  bp_entry_t             cur,
    output logic [btb_ways-1:0]   alloc_way,
    output logic [plru_width-1:0] new_plru,
    output logic [btb_ways-1:0]   new_valid
);

    logic [btb_ways-1:0] invalid;
    logic [btb_ways-1:0] first_invalid;
    logic [btb_ways-1:0] victim;

    // lookup only, nothing touched here
    plru_tree i_victim_tree (
        .node      (cur.plru),
        .touch_way ('0),
        .touched   (),
        .victim    (victim)
    );

    // isolate lowest set bit
    assign invalid       = ~cur.way_valid;
    assign first_invalid = invalid & (~invalid + btb_ways'(1));

    // hit way first, then a free way, then evict
    always_comb begin
        if (|cur.way_hit) begin
            alloc_way = cur.way_hit;
        end else if (|invalid) begin
            alloc_way = first_invalid;
        end else begin
            alloc_way = victim;
        end
    end

    assign new_valid = cur.way_valid | alloc_way;

    plru_tree i_touch_tree (
        .node      (cur.plru),
        .touch_way (alloc_way),
        .touched   (new_plru),
        .victim    ()
    );

endmodule

// File: logic/commit_update.sv
`timescale 1ns/1ps

module commit_update
    import bpu_entry_pkg::*;
(
    input  bp_entry_t cur,
    input  logic      taken,
    output bp_entry_t next
);

    logic [btb_ways-1:0]   alloc_way;
    logic [plru_width-1:0] new_plru;
    logic [btb_ways-1:0]   new_valid;
    logic                  ctr_max;
    logic                  ctr_min;

    btb_way_alloc i_way_alloc (
        .cur       (cur),
        .alloc_way (alloc_way),
        .new_plru  (new_plru),
        .new_valid (new_valid)
    );

    assign ctr_max = &cur.ctr;
    assign ctr_min = ~|cur.ctr;

    always_comb begin
        next = cur;

        // saturating counter toward the resolved direction
        if (taken && !ctr_max) begin
            next.ctr = cur.ctr + ctr_width'(1);
        end else if (!taken && !ctr_min) begin
            next.ctr = cur.ctr - ctr_width'(1);
        end

        // taken branch claims a btb way
        if (taken) begin
            next.way_valid = new_valid;
            next.way_hit   = alloc_way;
            next.plru      = new_plru;
        end
    end

endmodule

// File: logic/entry_storage.sv
`timescale 1ns/1ps

module entry_storage
    import bpu_entry_pkg::*;
#(
    parameter int depth = 8
) (
    input  logic      clk,
    input  logic      rst_n,

    ring_if.store     ring,

    input  bp_entry_t wr_entry,
    input  logic      taken,
    output bp_entry_t rd_entry
);

    localparam int idx_w = $clog2(depth);

    bp_entry_t             mem [depth];
    bp_entry_t             wr_rec;
    bp_entry_t             cmt_cur;
    bp_entry_t             cmt_next;
    logic [plru_width-1:0] wr_plru;

    // ==================================================
    // write path, tree touched toward the hit way
    // ==================================================
    plru_tree i_wr_touch (
        .node      (wr_entry.plru),
        .touch_way (wr_entry.way_hit),
        .touched   (wr_plru),
        .victim    ()
    );

    always_comb begin
        wr_rec      = wr_entry;
        wr_rec.plru = wr_plru;
    end

    // ==================================================
    // commit path, read-modify-write
    // ==================================================
    assign cmt_cur = mem[ring.cmt_idx];

    commit_update i_commit_update (
        .cur   (cmt_cur),
        .taken (taken),
        .next  (cmt_next)
    );

    // ==================================================
    // array
    // ==================================================
    // wr_idx and cmt_idx never meet while both are enabled
    for (genvar i = 0; i < depth; i++) begin : g_entry
        always_ff @(posedge clk or negedge rst_n) begin
            if (!rst_n) begin
                mem[i] <= '0;
            end else if (ring.wr_en && ring.wr_idx == idx_w'(i)) begin
                mem[i] <= wr_rec;
            end else if (ring.cmt_en && ring.cmt_idx == idx_w'(i)) begin
                mem[i] <= cmt_next;
            end
        end
    end

    assign rd_entry = mem[ring.rd_idx];

endmodule

// File: logic/entry_ring_ctrl.sv
`timescale 1ns/1ps

module entry_ring_ctrl #(
    parameter int depth = 8
) (
    input  logic   clk,
    input  logic   rst_n,
    input  logic   flush,

    input  logic   in_vld,
    output logic   in_rdy,

    input  logic   commit_vld,

    output logic   out_vld,
    input  logic   out_rdy,

    ring_if.ctrl   ring
);

    localparam int idx_w = $clog2(depth);
    localparam int ptr_w = idx_w + 1;

    // extra msb tells full from empty
    logic [ptr_w-1:0] wr_ptr;
    logic [ptr_w-1:0] cmt_ptr;
    logic [ptr_w-1:0] rd_ptr;
    logic [ptr_w-1:0] cmt_ptr_nxt;
    logic [ptr_w-1:0] occupancy;
    logic             wr_fire;
    logic             rd_fire;

    // ==================================================
    // handshakes
    // ==================================================
    assign occupancy = wr_ptr - rd_ptr;
    assign in_rdy    = occupancy < ptr_w'(depth);
    assign out_vld   = cmt_ptr != rd_ptr;

    // writes during flush are dropped
    assign wr_fire   = in_vld && in_rdy && !flush;
    assign rd_fire   = out_vld && out_rdy;

    assign cmt_ptr_nxt = commit_vld ? cmt_ptr + ptr_w'(1) : cmt_ptr;

    // ==================================================
    // pointers
    // ==================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
        end else if (flush) begin
            // rewind to commit point, same-cycle commit kept
            wr_ptr <= cmt_ptr_nxt;
        end else if (wr_fire) begin
            wr_ptr <= wr_ptr + ptr_w'(1);
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cmt_ptr <= '0;
            rd_ptr  <= '0;
        end else begin
            cmt_ptr <= cmt_ptr_nxt;
            if (rd_fire) begin
                rd_ptr <= rd_ptr + ptr_w'(1);
            end
        end
    end

    // storage requests
    assign ring.wr_en   = wr_fire;
    assign ring.wr_idx  = wr_ptr[idx_w-1:0];
    assign ring.cmt_en  = commit_vld;
    assign ring.cmt_idx = cmt_ptr[idx_w-1:0];
    assign ring.rd_idx  = rd_ptr[idx_w-1:0];

endmodule

// File: logic/bpu_entry_buffer.sv
`timescale 1ns/1ps

module bpu_entry_buffer
    import bpu_entry_pkg::*;
#(
    parameter int depth = 8
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  flush,

    input  logic                  in_vld,
    output logic                  in_rdy,
    input  logic [pc_width-1:0]   in_pc,
    input  logic [ctr_width-1:0]  in_ctr,
    input  logic [btb_ways-1:0]   in_way_valid,
    input  logic [btb_ways-1:0]   in_way_hit,
    input  logic [plru_width-1:0] in_plru,

    input  logic                  commit_vld,
    input  logic                  commit_taken,

    output logic                  out_vld,
    input  logic                  out_rdy,
    output logic [pc_width-1:0]   out_pc,
    output logic [ctr_width-1:0]  out_ctr,
    output logic [btb_ways-1:0]   out_way_valid,
    output logic [btb_ways-1:0]   out_way_hit,
    output logic [plru_width-1:0] out_plru
);

    bp_entry_t wr_entry;
    bp_entry_t rd_entry;

    ring_if #(.depth(depth)) ring ();

    entry_ring_ctrl #(.depth(depth)) i_entry_ring_ctrl (
        .clk        (clk),
        .rst_n      (rst_n),
        .flush      (flush),
        .in_vld     (in_vld),
        .in_rdy     (in_rdy),
        .commit_vld (commit_vld),
        .out_vld    (out_vld),
        .out_rdy    (out_rdy),
        .ring       (ring.ctrl)
    );

    entry_storage #(.depth(depth)) i_entry_storage (
        .clk      (clk),
        .rst_n    (rst_n),
        .ring     (ring.store),
        .wr_entry (wr_entry),
        .taken    (commit_taken),
        .rd_entry (rd_entry)
    );

    // pack / unpack
    assign wr_entry = '{
        pred_pc:   in_pc,
        ctr:       in_ctr,
        way_valid: in_way_valid,
        way_hit:   in_way_hit,
        plru:      in_plru
    };

    assign out_pc        = rd_entry.pred_pc;
    assign out_ctr       = rd_entry.ctr;
    assign out_way_valid = rd_entry.way_valid;
    assign out_way_hit   = rd_entry.way_hit;
    assign out_plru      = rd_entry.plru;

endmodule

// File: bench/bpu_entry_buffer_props.sv
`timescale 1ns/1ps

module bpu_entry_buffer_props #(
    parameter int depth = 8
) (
    input logic                   clk,
    input logic                   rst_n,
    input logic                   commit_vld,
    input logic                   out_vld,
    input logic [$clog2(depth):0] wr_ptr,
    input logic [$clog2(depth):0] cmt_ptr,
    input logic [$clog2(depth):0] rd_ptr
);

    logic [$clog2(depth):0] occupancy;

    assign occupancy = wr_ptr - rd_ptr;

    // commit only behind the write pointer
    assert property (@(posedge clk) disable iff (!rst_n)
        commit_vld |-> cmt_ptr != wr_ptr)
        else $error("commit while every written record is already committed");

    assert property (@(posedge clk) disable iff (!rst_n)
        occupancy <= ($clog2(depth) + 1)'(depth))
        else $error("occupancy above depth");

    assert property (@(posedge clk) $rose(rst_n) |-> !out_vld)
        else $error("out_vld high in the first cycle after reset");

endmodule

bind entry_ring_ctrl bpu_entry_buffer_props #(.depth(depth)) i_ring_props (
    .clk        (clk),
    .rst_n      (rst_n),
    .commit_vld (commit_vld),
    .out_vld    (out_vld),
    .wr_ptr     (wr_ptr),
    .cmt_ptr    (cmt_ptr),
    .rd_ptr     (rd_ptr)
);

// File: bench/bpu_entry_buffer_tb.sv
`timescale 1ns/1ps

module bpu_entry_buffer_tb
    import bpu_entry_pkg::*;
;

    localparam int depth      = 8;
    localparam int wait_limit = 200;

    logic                  clk;
    logic                  rst_n;
    logic                  flush;
    logic                  in_vld;
    logic                  in_rdy;
    logic [pc_width-1:0]   in_pc;
    logic [ctr_width-1:0]  in_ctr;
    logic [btb_ways-1:0]   in_way_valid;
    logic [btb_ways-1:0]   in_way_hit;
    logic [plru_width-1:0] in_plru;
    logic                  commit_vld;
    logic                  commit_taken;
    logic                  out_vld;
    logic                  out_rdy;
    logic [pc_width-1:0]   out_pc;
    logic [ctr_width-1:0]  out_ctr;
    logic [btb_ways-1:0]   out_way_valid;
    logic [btb_ways-1:0]   out_way_hit;
    logic [plru_width-1:0] out_plru;

    // model: written but uncommitted, and committed but not yet read
    bp_entry_t   pend_q[$];
    bp_entry_t   exp_q[$];
    bp_entry_t   held_rec;
    logic        stalled;
    logic [15:0] lfsr;
    int          errors;
    int          timeouts;

    bpu_entry_buffer #(.depth(depth)) i_bpu_entry_buffer (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // ==================================================
    // random source
    // ==================================================
    function automatic logic lfsr_bit();
        logic lsb;
        lsb  = lfsr[0];
        lfsr = lfsr >> 1;
        if (lsb) begin
            lfsr = lfsr ^ 16'hb400;
        end
        return lsb;
    endfunction

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v[i] = lfsr_bit();
        end
        return v;
    endfunction

    function automatic bp_entry_t make_record();
        bp_entry_t rec;
        rec.pred_pc   = take_bits(pc_width);
        rec.ctr       = ctr_width'(take_bits(ctr_width));
        rec.way_valid = btb_ways'(take_bits(btb_ways));
        rec.way_hit   = '0;
        if (lfsr_bit()) begin
            rec.way_hit[take_bits(2)] = 1'b1;
        end
        rec.plru = plru_width'(take_bits(plru_width));
        return rec;
    endfunction

    // ==================================================
    // reference model
    // ==================================================
    function automatic logic [plru_width-1:0] touch_node(input logic [plru_width-1:0] node,
                                                         input int w);
        logic [plru_width-1:0] t;
        t = node;
        if (w < 2) begin
            t[0] = 1'b1;
            t[1] = (w % 2 == 0);
        end else begin
            t[0] = 1'b0;
            t[2] = (w % 2 == 0);
        end
        return t;
    endfunction

    function automatic int victim_way(input logic [plru_width-1:0] node);
        if (node[0]) begin
            return node[2] ? 3 : 2;
        end
        return node[1] ? 1 : 0;
    endfunction

    function automatic bp_entry_t stored_after_write(input bp_entry_t rec);
        bp_entry_t s;
        s = rec;
        for (int i = 0; i < btb_ways; i++) begin
            if (rec.way_hit[i]) begin
                s.plru = touch_node(rec.plru, i);
            end
        end
        return s;
    endfunction

    function automatic bp_entry_t expected_commit(input bp_entry_t cur, input logic taken);
        bp_entry_t           nxt;
        logic [btb_ways-1:0] way;
        int                  w;
        nxt = cur;
        if (taken && cur.ctr != '1) begin
            nxt.ctr = cur.ctr + ctr_width'(1);
        end else if (!taken && cur.ctr != '0) begin
            nxt.ctr = cur.ctr - ctr_width'(1);
        end
        if (taken) begin
            w = -1;
            for (int i = 0; i < btb_ways; i++) begin
                if (cur.way_hit[i]) begin
                    w = i;
                end
            end
            // lowest invalid way wins
            for (int i = btb_ways - 1; i >= 0 && !(|cur.way_hit); i--) begin
                if (!cur.way_valid[i]) begin
                    w = i;
                end
            end
            if (w < 0) begin
                w = victim_way(cur.plru);
            end
            way           = '0;
            way[w]        = 1'b1;
            nxt.way_valid = cur.way_valid | way;
            nxt.way_hit   = way;
            nxt.plru      = touch_node(cur.plru, w);
        end
        return nxt;
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            errors++;
            $display("Error at %0t: %s expected %h, got %h", $time, name, expected, actual);
        end
    endtask

    task automatic compare_record(input bp_entry_t expected, input bp_entry_t actual);
        check_value("out_pc", expected.pred_pc, actual.pred_pc);
        check_value("out_ctr", 32'(expected.ctr), 32'(actual.ctr));
        check_value("out_way_valid", 32'(expected.way_valid), 32'(actual.way_valid));
        check_value("out_way_hit", 32'(expected.way_hit), 32'(actual.way_hit));
        check_value("out_plru", 32'(expected.plru), 32'(actual.plru));
    endtask

    // ==================================================
    // output compare and model update
    // ==================================================
    always @(posedge clk) begin : monitor
        bp_entry_t act_rec;
        bp_entry_t wr_rec;
        if (!rst_n) begin
            stalled = 1'b0;
        end else begin
            act_rec = '{out_pc, out_ctr, out_way_valid, out_way_hit, out_plru};
            wr_rec  = '{in_pc, in_ctr, in_way_valid, in_way_hit, in_plru};
            // valid and ready follow the model queues
            check_value("out_vld", 32'(exp_q.size() != 0), 32'(out_vld));
            check_value("in_rdy", 32'(pend_q.size() + exp_q.size() < depth), 32'(in_rdy));
            if (stalled) begin
                compare_record(held_rec, act_rec);
            end
            if (out_vld && out_rdy) begin
                if (exp_q.size() == 0) begin
                    errors++;
                    $display("record with pc %h left the buffer but none was expected", out_pc);
                end else begin
                    compare_record(exp_q.pop_front(), act_rec);
                end
            end
            stalled  = out_vld && !out_rdy;
            held_rec = act_rec;
            if (commit_vld && pend_q.size() != 0) begin
                exp_q.push_back(expected_commit(pend_q.pop_front(), commit_taken));
            end
            if (flush) begin
                pend_q.delete();
            end else if (in_vld && in_rdy) begin
                pend_q.push_back(stored_after_write(wr_rec));
            end
        end
    end

    // ==================================================
    // stimulus tasks, all start and end on a falling edge
    // ==================================================
    task automatic drive_record(input bp_entry_t rec);
        in_pc        = rec.pred_pc;
        in_ctr       = rec.ctr;
        in_way_valid = rec.way_valid;
        in_way_hit   = rec.way_hit;
        in_plru      = rec.plru;
    endtask

    task automatic push_record(input bp_entry_t rec);
        int waited;
        waited = 0;
        drive_record(rec);
        in_vld = 1'b1;
        while (!in_rdy && waited < wait_limit) begin
            @(negedge clk);
            waited++;
        end
        if (!in_rdy) begin
            timeouts++;
            $display("timed out waiting for the buffer to accept a record");
        end
        @(negedge clk);
        in_vld = 1'b0;
    endtask

    task automatic commit_one(input logic taken);
        if (pend_q.size() == 0) begin
            errors++;
            $display("no uncommitted record left for a commit");
        end else begin
            commit_vld   = 1'b1;
            commit_taken = taken;
            @(negedge clk);
            commit_vld   = 1'b0;
        end
    endtask

    task automatic read_one();
        int waited;
        waited  = 0;
        out_rdy = 1'b1;
        while (!out_vld && waited < wait_limit) begin
            @(negedge clk);
            waited++;
        end
        if (!out_vld) begin
            timeouts++;
            $display("timed out waiting for a record at the output");
        end
        @(negedge clk);
        out_rdy = 1'b0;
    endtask

    task automatic drain_output();
        int waited;
        waited  = 0;
        out_rdy = 1'b1;
        while (exp_q.size() != 0 && waited < wait_limit) begin
            @(negedge clk);
            waited++;
        end
        if (exp_q.size() != 0) begin
            timeouts++;
            $display("timed out draining committed records, %0d left", exp_q.size());
        end
        out_rdy = 1'b0;
        check_value("out_vld", 32'd0, 32'(out_vld));
    endtask

    // ==================================================
    // test sequence
    // ==================================================
    initial begin : stimulus
        bp_entry_t rec;
        errors       = 0;
        timeouts     = 0;
        lfsr         = 16'd86;
        stalled      = 1'b0;
        rst_n        = 1'b0;
        flush        = 1'b0;
        in_vld       = 1'b0;
        commit_vld   = 1'b0;
        commit_taken = 1'b0;
        out_rdy      = 1'b0;
        drive_record('0);
        repeat (2) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);

        // fill without reads
        for (int i = 0; i < depth; i++) begin
            check_value("in_rdy", 32'd1, 32'(in_rdy));
            push_record(make_record());
        end
        check_value("in_rdy", 32'd0, 32'(in_rdy));
        commit_one(lfsr_bit());
        read_one();
        check_value("in_rdy", 32'd1, 32'(in_rdy));
        while (pend_q.size() != 0) begin
            commit_one(lfsr_bit());
        end
        drain_output();

        // counter saturation in both directions
        out_rdy = 1'b1;
        for (int c = 0; c < 4; c++) begin
            for (int t = 0; t < 2; t++) begin
                rec     = make_record();
                rec.ctr = ctr_width'(c);
                push_record(rec);
                commit_one(t[0]);
            end
        end

        // allocation: hit, free way, then victim for every tree state
        rec           = make_record();
        rec.way_valid = 4'b0011;
        rec.way_hit   = 4'b0010;
        push_record(rec);
        commit_one(1'b1);
        rec.way_valid = 4'b1001;
        rec.way_hit   = '0;
        push_record(rec);
        commit_one(1'b1);
        for (int p = 0; p < 8; p++) begin
            rec           = make_record();
            rec.way_valid = '1;
            rec.way_hit   = '0;
            rec.plru      = plru_width'(p);
            push_record(rec);
            commit_one(1'b1);
        end

        // write-time touch seen through not-taken commits
        for (int w = 0; w < btb_ways; w++) begin
            rec            = make_record();
            rec.way_hit    = '0;
            rec.way_hit[w] = 1'b1;
            push_record(rec);
            commit_one(1'b0);
        end
        drain_output();

        // flush with a commit and a dropped write in the same cycle
        for (int i = 0; i < 6; i++) begin
            push_record(make_record());
        end
        repeat (3) commit_one(lfsr_bit());
        drive_record(make_record());
        in_vld       = 1'b1;
        flush        = 1'b1;
        commit_vld   = 1'b1;
        commit_taken = lfsr_bit();
        @(negedge clk);
        in_vld     = 1'b0;
        flush      = 1'b0;
        commit_vld = 1'b0;
        for (int i = 0; i < 3; i++) begin
            push_record(make_record());
        end
        repeat (3) commit_one(lfsr_bit());
        drain_output();

        // random traffic under back-pressure
        for (int cyc = 0; cyc < 300; cyc++) begin
            out_rdy = lfsr_bit();
            in_vld  = lfsr_bit();
            if (in_vld) begin
                drive_record(make_record());
            end
            commit_vld   = (pend_q.size() != 0) && lfsr_bit();
            commit_taken = lfsr_bit();
            @(negedge clk);
        end
        in_vld     = 1'b0;
        commit_vld = 1'b0;
        while (pend_q.size() != 0) begin
            commit_one(lfsr_bit());
        end
        drain_output();

        $display("errors: %0d, timeouts: %0d", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

// File: bpu_entry_buffer.f
logic/bpu_entry_pkg.sv
logic/ring_if.sv
logic/plru_tree.sv
logic/btb_way_alloc.sv
logic/commit_update.sv
logic/entry_storage.sv
logic/entry_ring_ctrl.sv
logic/bpu_entry_buffer.sv
bench/bpu_entry_buffer_props.sv
bench/bpu_entry_buffer_tb.sv
